// File: bench/mem_pipe_input.txt
# Columns (hex): op offset_sel pc instr rs1 rs2 imm kill_ex1 kill_ex3 backpressure
# Ops: LB 0 LH 1 LW 2 LD 3 LBU 4 LHU 5 LWU 6 SB 7 SH 8 SW 9 SD a, CSR b-10, FAULT 11, NOP 1f
# Stores of every size, both address forms
0a 0 0 0 100 8899aabbccddeeff 8 0 0 0
09 1 0 0 110 f1e2d3c4 0 0 0 0
08 0 0 0 110 8001 4 0 0 0
07 1 0 0 117 9a 0 0 0 0
# Loads of every size back from the same addresses
03 1 0 0 108 0 0 0 0 0
02 0 0 0 100 0 c 0 0 0
06 0 0 0 100 0 c 0 0 0
01 0 0 0 100 0 e 0 0 0
05 1 0 0 10e 0 0 0 0 0
00 1 0 0 10f 0 0 0 0 0
04 0 0 0 10f 0 0 0 0 0
02 1 0 0 110 0 0 0 0 0
03 0 0 0 100 0 10 0 0 0
01 1 0 0 114 0 0 0 0 0
# Misaligned accesses and front-end faults
09 0 0 0 120 11223344 2 0 0 0
03 1 0 0 104 0 0 0 0 0
01 0 0 0 100 0 1 0 0 0
08 1 0 0 121 ffff 0 0 0 0
11 0 1002 0 0 0 0 0 0 0
11 0 7f00000002 0 0 0 0 0 0 0
03 0 0 0 120 0 0 0 0 0
# Outside the scratchpad window
0a 1 0 0 800 deadbeef 0 0 0 0
0a 0 0 0 fffffffffffffff0 5a5a 8 0 0 0
03 1 0 0 0 0 0 0 0 0
00 0 0 0 7f8 0 10 0 0 0
# Killed in ex1, then a load that sees no write
0a 1 0 0 130 5555 0 1 0 0
03 1 0 0 130 0 0 0 0 0
# CSR commands, back to back, one killed in ex3
0b 0 0 30001073 1234 0 5 0 0 0
0f 0 0 34102073 abc 0 1f 0 0 0
0d 0 0 30503073 77 0 0 0 1 0
10 0 0 c0007073 99 0 3 0 0 0
1f 0 0 0 0 0 0 0 0 0
# Burst under random back-pressure
0a 1 0 0 200 0123456789abcdef 0 0 0 1
0a 0 0 0 200 fedcba9876543210 8 0 0 1
09 1 0 0 210 80000001 0 0 0 1
07 0 0 0 210 7f 3 0 0 1
08 1 0 0 216 c3a5 0 0 0 1
03 1 0 0 200 0 0 0 0 1
03 0 0 0 200 0 8 0 0 1
02 1 0 0 210 0 0 0 0 1
06 1 0 0 214 0 0 0 0 1
01 0 0 0 210 0 6 0 0 1
04 1 0 0 213 0 0 0 0 1
0a 1 0 0 2c1 1 0 0 0 1
00 0 0 0 200 0 f 0 0 1
05 1 0 0 208 0 0 0 0 1

// File: all.f
+incdir+common
common/mem_pipe_pkg.sv
design/mem_pipe_issue.sv
design/cmd_queue.sv
dmem/dmem_port.sv
design/mem_pipe_top.sv
bench/tb_mem_pipe.sv

// File: Bender.yml
package:
  name: mem_pipe

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mem_pipe_pkg.sv
      - design/mem_pipe_issue.sv
      - design/cmd_queue.sv
      - dmem/dmem_port.sv
      - design/mem_pipe_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_mem_pipe.sv

// File: bench/tb_mem_pipe.sv
`timescale 1ns/1ps
`include "mem_pipe_params.svh"

module tb_mem_pipe;

   localparam int TIMEOUT_CYCLES = 200;
   localparam int SHADOW_BYTES   = `DMEM_WORDS * 8;

   logic                    clk;
   logic                    arst_n;
   logic                    decode_v;
   mem_pipe_pkg::fu_op_e    fu_op;
   logic                    offset_sel;
   logic [`VADDR_WIDTH-1:0] pc;
   logic [31:0]             instr;
   logic [`REG_WIDTH-1:0]   rs1;
   logic [`REG_WIDTH-1:0]   rs2;
   logic [`REG_WIDTH-1:0]   imm;
   logic                    decode_ready;
   logic                    kill_ex1;
   logic                    kill_ex3;
   logic                    csr_cmd_v;
   mem_pipe_pkg::csr_cmd_s  csr_cmd;
   logic                    resp_ready;
   logic                    resp_v;
   logic                    exc_v;
   logic                    miss_v;
   logic [`REG_WIDTH-1:0]   data;

   // Reference model state
   logic [7:0]              shadow [SHADOW_BYTES];
   logic [63:0]             exp_data_q [$];
   logic [1:0]              exp_flag_q [$];
   logic [1:0]              resp_flags;
   int                      errors;
   int                      resp_count;
   int                      mem_records;
   logic [31:0]             lfsr;
   logic                    bp_en;
   logic [1:0]              kill3_pipe;
   logic                    cur_kill3;

   // Expected CSR command, two stages behind the decode
   logic [1:0]              csr_exp_v;
   logic [1:0]              csr_exp_kill;
   logic [4:0]              csr_exp_op [2];
   logic [11:0]             csr_exp_addr [2];
   logic [63:0]             csr_exp_data [2];

   mem_pipe_top i_dut (
      .clk_i          (clk),
      .arst_n_i       (arst_n),
      .decode_v_i     (decode_v),
      .fu_op_i        (fu_op),
      .offset_sel_i   (offset_sel),
      .pc_i           (pc),
      .instr_i        (instr),
      .rs1_i          (rs1),
      .rs2_i          (rs2),
      .imm_i          (imm),
      .decode_ready_o (decode_ready),
      .kill_ex1_i     (kill_ex1),
      .kill_ex3_i     (kill_ex3),
      .csr_cmd_v_o    (csr_cmd_v),
      .csr_cmd_o      (csr_cmd),
      .resp_ready_i   (resp_ready),
      .resp_v_o       (resp_v),
      .exc_v_o        (exc_v),
      .miss_v_o       (miss_v),
      .data_o         (data)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(logic [31:0] state);
      logic lsb;
      lsb   = state[0];
      state = state >> 1;
      if (lsb)
      begin
         state = state ^ 32'h8020_0003;
      end
      return state;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   function automatic int op_bytes(mem_pipe_pkg::fu_op_e op);
      int n;
      case (op)
         mem_pipe_pkg::LB, mem_pipe_pkg::LBU, mem_pipe_pkg::SB: n = 1;
         mem_pipe_pkg::LH, mem_pipe_pkg::LHU, mem_pipe_pkg::SH: n = 2;
         mem_pipe_pkg::LW, mem_pipe_pkg::LWU, mem_pipe_pkg::SW: n = 4;
         default: n = 8;
      endcase
      return n;
   endfunction

   // Byte-wide shadow memory, little endian
   task automatic model_access(input mem_pipe_pkg::fu_op_e op, input logic [63:0] addr,
                               input logic [63:0] wdata);
      int          nbytes;
      logic        exc;
      logic        miss;
      logic        ld;
      logic        st;
      logic [63:0] val;
      ld     = op inside {mem_pipe_pkg::LB, mem_pipe_pkg::LH, mem_pipe_pkg::LW,
                          mem_pipe_pkg::LD, mem_pipe_pkg::LBU, mem_pipe_pkg::LHU,
                          mem_pipe_pkg::LWU};
      st     = op inside {mem_pipe_pkg::SB, mem_pipe_pkg::SH, mem_pipe_pkg::SW,
                          mem_pipe_pkg::SD};
      nbytes = op_bytes(op);
      exc    = (op == mem_pipe_pkg::INSTR_MISALIGNED) || ((addr % nbytes) != 0);
      miss   = (addr >> 3) >= `DMEM_WORDS;
      val    = '0;
      if (!exc && !miss)
      begin
         for (int i = 0; i < nbytes; i++)
         begin
            if (st)
            begin
               shadow[addr + i] = wdata[i*8 +: 8];
            end
            else if (ld)
            begin
               val[i*8 +: 8] = shadow[addr + i];
            end
         end
         // Signed loads extend the top bit of the accessed size
         if (ld && (op inside {mem_pipe_pkg::LB, mem_pipe_pkg::LH, mem_pipe_pkg::LW})
             && val[nbytes*8-1])
         begin
            val = val | ~((64'd1 << (nbytes * 8)) - 64'd1);
         end
      end
      exp_data_q.push_back(val);
      exp_flag_q.push_back({exc, miss});
   endtask

   // One cycle of stimulus, applied at the falling edge
   task automatic next_cycle();
      logic b0;
      logic b1;
      @(negedge clk);
      decode_v = 1'b0;
      if (bp_en)
      begin
         lfsr       = lfsr_next(lfsr);
         b0         = lfsr[0];
         lfsr       = lfsr_next(lfsr);
         b1         = lfsr[0];
         resp_ready = b0 & b1;
      end
      else
      begin
         resp_ready = 1'b1;
      end
      kill_ex3   = kill3_pipe[1];
      kill3_pipe = {kill3_pipe[0], 1'b0};
   endtask

   // Response and CSR checks on the rising edge, before the DUT updates
   always @(posedge clk)
   begin
      if (arst_n)
      begin
         if (resp_v && resp_ready)
         begin
            resp_count++;
            if (exp_data_q.size() == 0)
            begin
               errors++;
               $display("A memory response arrived that no command asked for");
            end
            else
            begin
               resp_flags = exp_flag_q.pop_front();
               check_value("data_o", data, exp_data_q.pop_front());
               check_value("exc_v_o", exc_v, resp_flags[1]);
               check_value("miss_v_o", miss_v, resp_flags[0]);
            end
         end
         check_value("csr_cmd_v_o", csr_cmd_v, csr_exp_v[1] & ~csr_exp_kill[1]);
         if (csr_exp_v[1] && !csr_exp_kill[1])
         begin
            check_value("csr_cmd_o.csr_op", csr_cmd.csr_op, csr_exp_op[1]);
            check_value("csr_cmd_o.csr_addr", csr_cmd.csr_addr, csr_exp_addr[1]);
            check_value("csr_cmd_o.data", csr_cmd.data, csr_exp_data[1]);
         end
         csr_exp_v[1]    = csr_exp_v[0];
         csr_exp_kill[1] = csr_exp_kill[0];
         csr_exp_op[1]   = csr_exp_op[0];
         csr_exp_addr[1] = csr_exp_addr[0];
         csr_exp_data[1] = csr_exp_data[0];
         csr_exp_v[0]    = decode_v && (fu_op inside {mem_pipe_pkg::CSRRW, mem_pipe_pkg::CSRRS,
                           mem_pipe_pkg::CSRRC, mem_pipe_pkg::CSRRWI, mem_pipe_pkg::CSRRSI,
                           mem_pipe_pkg::CSRRCI});
         csr_exp_kill[0] = cur_kill3;
         csr_exp_op[0]   = fu_op;
         csr_exp_addr[0] = instr[31:20];
         csr_exp_data[0] = (fu_op inside {mem_pipe_pkg::CSRRWI, mem_pipe_pkg::CSRRSI,
                           mem_pipe_pkg::CSRRCI}) ? imm : rs1;
      end
   end

   initial
   begin
      int                   fd;
      int                   n;
      int                   wait_cnt;
      string                line;
      logic [63:0]          f_op;
      logic [63:0]          f_sel;
      logic [63:0]          f_pc;
      logic [63:0]          f_instr;
      logic [63:0]          f_rs1;
      logic [63:0]          f_rs2;
      logic [63:0]          f_imm;
      logic [63:0]          f_k1;
      logic [63:0]          f_k3;
      logic [63:0]          f_bp;
      logic [63:0]          eaddr;
      logic                 timed_out;
      logic                 saw_full;
      mem_pipe_pkg::fu_op_e op;

      arst_n       = 1'b0;
      decode_v     = 1'b0;
      fu_op        = mem_pipe_pkg::NOP;
      offset_sel   = 1'b0;
      pc           = '0;
      instr        = '0;
      rs1          = '0;
      rs2          = '0;
      imm          = '0;
      kill_ex1     = 1'b0;
      kill_ex3     = 1'b0;
      resp_ready   = 1'b1;
      errors       = 0;
      resp_count   = 0;
      mem_records  = 0;
      lfsr         = 32'h3956_1fcc;
      bp_en        = 1'b0;
      kill3_pipe   = '0;
      cur_kill3    = 1'b0;
      csr_exp_v    = '0;
      csr_exp_kill = '0;
      timed_out    = 1'b0;
      saw_full     = 1'b0;
      for (int i = 0; i < SHADOW_BYTES; i++)
      begin
         shadow[i] = 8'h00;
      end

      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      fd = $fopen("bench/mem_pipe_input.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("Could not open the stimulus file bench/mem_pipe_input.txt");
      end
      else
      begin
         while (!timed_out && !$feof(fd))
         begin
            line = "";
            if ($fgets(line, fd) == 0)
            begin
               continue;
            end
            if (line.len() == 0 || line[0] == "#")
            begin
               continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_op, f_sel, f_pc,
                        f_instr, f_rs1, f_rs2, f_imm, f_k1, f_k3, f_bp);
            if (n != 10)
            begin
               continue;
            end

            next_cycle();
            // Decoder holds off while the queue is full
            wait_cnt = 0;
            while (!decode_ready && !timed_out)
            begin
               saw_full = 1'b1;
               wait_cnt++;
               if (wait_cnt > TIMEOUT_CYCLES)
               begin
                  timed_out = 1'b1;
                  errors++;
                  $display("decode_ready_o never came back high");
               end
               else
               begin
                  next_cycle();
               end
            end
            if (timed_out)
            begin
               continue;
            end

            op         = mem_pipe_pkg::fu_op_e'(f_op[4:0]);
            bp_en      = f_bp[0];
            fu_op      = op;
            offset_sel = f_sel[0];
            pc         = f_pc[`VADDR_WIDTH-1:0];
            instr      = f_instr[31:0];
            rs1        = f_rs1;
            rs2        = f_rs2;
            // Register-only records put junk on the immediate bus
            imm        = f_sel[0] ? ~f_imm : f_imm;
            kill_ex1   = f_k1[0];
            cur_kill3  = f_k3[0];
            decode_v   = 1'b1;
            kill3_pipe[0] = f_k3[0];
            if ((op <= mem_pipe_pkg::SD || op == mem_pipe_pkg::INSTR_MISALIGNED) && !f_k1[0])
            begin
               if (op == mem_pipe_pkg::INSTR_MISALIGNED)
               begin
                  eaddr = {{(64 - `VADDR_WIDTH){f_pc[`VADDR_WIDTH-1]}},
                           f_pc[`VADDR_WIDTH-1:0]};
               end
               else
               begin
                  eaddr = f_rs1 + (f_sel[0] ? 64'd0 : f_imm);
               end
               model_access(op, eaddr, f_rs2);
               mem_records++;
            end
         end
         $fclose(fd);
      end

      bp_en = 1'b0;
      next_cycle();
      wait_cnt = 0;
      while (!timed_out && exp_data_q.size() != 0)
      begin
         wait_cnt++;
         if (wait_cnt > TIMEOUT_CYCLES)
         begin
            timed_out = 1'b1;
            errors++;
            $display("resp_v_o never delivered all expected responses");
         end
         else
         begin
            next_cycle();
         end
      end
      // Lets the last CSR command reach its output cycle
      repeat (3) next_cycle();

      if (!timed_out)
      begin
         check_value("response count", resp_count, mem_records);
         check_value("decode_ready_o low seen", saw_full, 1'b1);
      end
      $display("Errors: %0d, responses: %0d, memory records: %0d", errors, resp_count,
               mem_records);
      if (errors == 0)
      begin
         $display("TEST PASS");
      end
      else
      begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: design/mem_pipe_top.sv
`timescale 1ns/1ps
`include "mem_pipe_params.svh"

module mem_pipe_top (
   input  logic                    clk_i,
   input  logic                    arst_n_i,

   input  logic                    decode_v_i,
   input  mem_pipe_pkg::fu_op_e    fu_op_i,
   input  logic                    offset_sel_i,
   input  logic [`VADDR_WIDTH-1:0] pc_i,
   input  logic [31:0]             instr_i,
   input  logic [`REG_WIDTH-1:0]   rs1_i,
   input  logic [`REG_WIDTH-1:0]   rs2_i,
   input  logic [`REG_WIDTH-1:0]   imm_i,
   output logic                    decode_ready_o,

   input  logic                    kill_ex1_i,
   input  logic                    kill_ex3_i,

   output logic                    csr_cmd_v_o,
   output mem_pipe_pkg::csr_cmd_s  csr_cmd_o,

   input  logic                    resp_ready_i,
   output logic                    resp_v_o,
   output logic                    exc_v_o,
   output logic                    miss_v_o,
   output logic [`REG_WIDTH-1:0]   data_o
);

   logic                   issue_cmd_v;
   mem_pipe_pkg::mmu_cmd_s issue_cmd;
   logic                   queue_v;
   mem_pipe_pkg::mmu_cmd_s queue_cmd;
   logic                   dmem_ready;

   mem_pipe_issue i_issue (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .decode_v_i   (decode_v_i),
      .fu_op_i      (fu_op_i),
      .offset_sel_i (offset_sel_i),
      .pc_i         (pc_i),
      .instr_i      (instr_i),
      .rs1_i        (rs1_i),
      .rs2_i        (rs2_i),
      .imm_i        (imm_i),
      .kill_ex1_i   (kill_ex1_i),
      .kill_ex3_i   (kill_ex3_i),
      .cmd_v_o      (issue_cmd_v),
      .cmd_o        (issue_cmd),
      .csr_cmd_v_o  (csr_cmd_v_o),
      .csr_cmd_o    (csr_cmd_o)
   );

   // Queue space is what the decoder sees as ready
   cmd_queue #(
      .DEPTH  (`CMD_QUEUE_DEPTH),
      .item_t (mem_pipe_pkg::mmu_cmd_s)
   ) i_cmd_queue (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .v_i          (issue_cmd_v),
      .data_i       (issue_cmd),
      .ready_o      (decode_ready_o),
      .v_o          (queue_v),
      .data_o       (queue_cmd),
      .yumi_ready_i (dmem_ready)
   );

   dmem_port i_dmem_port (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .cmd_v_i      (queue_v),
      .cmd_i        (queue_cmd),
      .cmd_ready_o  (dmem_ready),
      .resp_ready_i (resp_ready_i),
      .resp_v_o     (resp_v_o),
      .exc_v_o      (exc_v_o),
      .miss_v_o     (miss_v_o),
      .data_o       (data_o)
   );

endmodule

// File: dmem/dmem_port.sv
`timescale 1ns/1ps
`include "mem_pipe_params.svh"

module dmem_port (
   input  logic                   clk_i,
   input  logic                   arst_n_i,

   input  logic                   cmd_v_i,
   input  mem_pipe_pkg::mmu_cmd_s cmd_i,
   output logic                   cmd_ready_o,

   input  logic                   resp_ready_i,
   output logic                   resp_v_o,
   output logic                   exc_v_o,
   output logic                   miss_v_o,
   output logic [`REG_WIDTH-1:0]  data_o
);

   localparam int IDX_W = $clog2(`DMEM_WORDS);

   logic [`REG_WIDTH-1:0] mem_q [`DMEM_WORDS];
   logic                  accept;
   logic                  is_ld;
   logic                  is_st;
   logic [1:0]            size;
   logic [2:0]            byte_off;
   logic [IDX_W-1:0]      idx;
   logic                  misaligned;
   logic                  fault_exc;
   logic                  fault_miss;
   logic [7:0]            be;
   logic [`REG_WIDTH-1:0] wdata;
   logic [`REG_WIDTH-1:0] rdata_shift;
   logic [`REG_WIDTH-1:0] load_data;
   logic                  resp_v_q;
   logic                  exc_q;
   logic                  miss_q;
   logic [`REG_WIDTH-1:0] data_q;

   // Free slot, or the held response leaves this cycle
   assign cmd_ready_o = ~resp_v_q | resp_ready_i;
   assign accept      = cmd_v_i & cmd_ready_o;

   assign is_ld    = mem_pipe_pkg::is_load(cmd_i.mem_op);
   assign is_st    = mem_pipe_pkg::is_store(cmd_i.mem_op);
   assign size     = mem_pipe_pkg::access_size(cmd_i.mem_op);
   assign byte_off = cmd_i.eaddr[2:0];
   assign idx      = cmd_i.eaddr[3 +: IDX_W];

   always_comb
   begin
      case (size)
         2'd0:    misaligned = 1'b0;
         2'd1:    misaligned = byte_off[0];
         2'd2:    misaligned = |byte_off[1:0];
         default: misaligned = |byte_off;
      endcase
   end

   assign fault_exc  = (cmd_i.mem_op == mem_pipe_pkg::INSTR_MISALIGNED)
                     | ((is_ld | is_st) & misaligned);
   // Window starts at 0, anything past the last double-word misses
   assign fault_miss = ({3'b000, cmd_i.eaddr[`EADDR_WIDTH-1:3]} >= `EADDR_WIDTH'(`DMEM_WORDS));

   // Lane select for stores
   always_comb
   begin
      case (size)
         2'd0:    be = 8'h01 << byte_off;
         2'd1:    be = 8'h03 << byte_off;
         2'd2:    be = 8'h0f << byte_off;
         default: be = 8'hff;
      endcase
   end

   assign wdata       = cmd_i.data << {byte_off, 3'b000};
   assign rdata_shift = mem_q[idx] >> {byte_off, 3'b000};

   always_comb
   begin
      case (cmd_i.mem_op)
         mem_pipe_pkg::LB:  load_data = {{(`REG_WIDTH-8){rdata_shift[7]}}, rdata_shift[7:0]};
         mem_pipe_pkg::LH:  load_data = {{(`REG_WIDTH-16){rdata_shift[15]}}, rdata_shift[15:0]};
         mem_pipe_pkg::LW:  load_data = {{(`REG_WIDTH-32){rdata_shift[31]}}, rdata_shift[31:0]};
         mem_pipe_pkg::LBU: load_data = {{(`REG_WIDTH-8){1'b0}}, rdata_shift[7:0]};
         mem_pipe_pkg::LHU: load_data = {{(`REG_WIDTH-16){1'b0}}, rdata_shift[15:0]};
         mem_pipe_pkg::LWU: load_data = {{(`REG_WIDTH-32){1'b0}}, rdata_shift[31:0]};
         default:           load_data = rdata_shift;
      endcase
   end

   // Scratchpad contents, faulting commands never write
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int i = 0; i < `DMEM_WORDS; i++)
         begin
            mem_q[i] <= '0;
         end
      end
      else if (accept && is_st && !fault_exc && !fault_miss)
      begin
         for (int b = 0; b < 8; b++)
         begin
            if (be[b])
            begin
               mem_q[idx][b*8 +: 8] <= wdata[b*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         resp_v_q <= 1'b0;
         exc_q    <= 1'b0;
         miss_q   <= 1'b0;
      end
      else if (accept)
      begin
         resp_v_q <= 1'b1;
         exc_q    <= fault_exc;
         miss_q   <= fault_miss;
      end
      else if (resp_ready_i)
      begin
         resp_v_q <= 1'b0;
      end
   end

   // Stores and faults return zero
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         data_q <= (is_ld && !fault_exc && !fault_miss) ? load_data : '0;
      end
   end

   assign resp_v_o = resp_v_q;
   assign exc_v_o  = resp_v_q & exc_q;
   assign miss_v_o = resp_v_q & miss_q;
   assign data_o   = data_q;

   // Held response must not change under back-pressure
   resp_hold_check: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (resp_v_o && !resp_ready_i) |=> resp_v_o && $stable(data_o)
                                      && $stable(exc_v_o) && $stable(miss_v_o)
   );

endmodule

// File: design/cmd_queue.sv
`timescale 1ns/1ps

module cmd_queue #(
   parameter int  DEPTH  = 4,
   parameter type item_t = logic [7:0]
) (
   input  logic  clk_i,
   input  logic  arst_n_i,

   input  logic  v_i,
   input  item_t data_i,
   output logic  ready_o,

   output logic  v_o,
   output item_t data_o,
   input  logic  yumi_ready_i
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   item_t            mem_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             full;
   logic             push;
   logic             pop;

   assign full    = (count_q == CNT_W'(DEPTH));
   assign ready_o = ~full;
   assign v_o     = (count_q != '0);
   assign data_o  = mem_q[rd_ptr_q];

   // Simultaneous push and pop leave the count unchanged
   assign push = v_i & ready_o;
   assign pop  = v_o & yumi_ready_i;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop)
         begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         if (push && !pop)
         begin
            count_q <= count_q + 1'b1;
         end
         else if (pop && !push)
         begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   // Storage holds payload only
   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         mem_q[wr_ptr_q] <= data_i;
      end
   end

   // Full with no pop means nothing may be written on that edge
   no_push_when_full: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (full && !pop) |=> (full && $stable(wr_ptr_q))
   );

endmodule

// File: design/mem_pipe_issue.sv
`timescale 1ns/1ps
`include "mem_pipe_params.svh"

module mem_pipe_issue (
   input  logic                   clk_i,
   input  logic                   arst_n_i,

   input  logic                   decode_v_i,
   input  mem_pipe_pkg::fu_op_e   fu_op_i,
   input  logic                   offset_sel_i,
   input  logic [`VADDR_WIDTH-1:0] pc_i,
   input  logic [31:0]            instr_i,
   input  logic [`REG_WIDTH-1:0]  rs1_i,
   input  logic [`REG_WIDTH-1:0]  rs2_i,
   input  logic [`REG_WIDTH-1:0]  imm_i,

   input  logic                   kill_ex1_i,
   input  logic                   kill_ex3_i,

   output logic                   cmd_v_o,
   output mem_pipe_pkg::mmu_cmd_s cmd_o,

   output logic                   csr_cmd_v_o,
   output mem_pipe_pkg::csr_cmd_s csr_cmd_o
);

   localparam int EADDR_PAD = `EADDR_WIDTH - `VADDR_WIDTH;

   logic                   fe_exc_v;
   logic                   mem_op_v;
   logic [`REG_WIDTH-1:0]  offset;
   logic                   csr_v;
   mem_pipe_pkg::csr_cmd_s csr_cmd_li;
   logic [1:0]             csr_v_q;
   mem_pipe_pkg::csr_cmd_s csr_cmd_s1_q;
   mem_pipe_pkg::csr_cmd_s csr_cmd_s2_q;

   // Front-end fault rides the memory path with the PC as address
   assign fe_exc_v = (fu_op_i == mem_pipe_pkg::INSTR_MISALIGNED);

   assign mem_op_v = mem_pipe_pkg::is_load(fu_op_i)
                   | mem_pipe_pkg::is_store(fu_op_i)
                   | fe_exc_v;

   // Register-only form drops the immediate
   assign offset = offset_sel_i ? '0 : imm_i;

   // Memory command goes out in the decode cycle
   assign cmd_v_o = decode_v_i & mem_op_v & ~kill_ex1_i;

   always_comb
   begin
      cmd_o.mem_op = fu_op_i;
      cmd_o.data   = rs2_i;
      if (fe_exc_v)
      begin
         cmd_o.eaddr = {{EADDR_PAD{pc_i[`VADDR_WIDTH-1]}}, pc_i};
      end
      else
      begin
         cmd_o.eaddr = rs1_i + offset;
      end
   end

   assign csr_v = decode_v_i & mem_pipe_pkg::is_csr(fu_op_i);

   always_comb
   begin
      csr_cmd_li.csr_op   = fu_op_i;
      csr_cmd_li.csr_addr = instr_i[31:20];
      csr_cmd_li.data     = mem_pipe_pkg::is_csr_imm(fu_op_i) ? imm_i : rs1_i;
   end

   // Two-stage delay so the CSR command lines up with ex3
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         csr_v_q <= '0;
      end
      else
      begin
         csr_v_q <= {csr_v_q[0], csr_v};
      end
   end

   always_ff @(posedge clk_i)
   begin
      csr_cmd_s1_q <= csr_cmd_li;
      csr_cmd_s2_q <= csr_cmd_s1_q;
   end

   // A late kill squashes the command in its output cycle
   assign csr_cmd_v_o = csr_v_q[1] & ~kill_ex3_i;
   assign csr_cmd_o   = csr_cmd_s2_q;

   // Only memory ops and front-end faults may reach the queue
   cmd_op_check: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      cmd_v_o |-> !(mem_pipe_pkg::is_csr(cmd_o.mem_op)
                    || cmd_o.mem_op == mem_pipe_pkg::NOP)
   );

endmodule

// File: common/mem_pipe_pkg.sv
`include "mem_pipe_params.svh"

package mem_pipe_pkg;

   // Functional unit operations handled by the memory pipe
   typedef enum logic [4:0] {
      LB               = 5'd0,
      LH               = 5'd1,
      LW               = 5'd2,
      LD               = 5'd3,
      LBU              = 5'd4,
      LHU              = 5'd5,
      LWU              = 5'd6,
      SB               = 5'd7,
      SH               = 5'd8,
      SW               = 5'd9,
      SD               = 5'd10,
      CSRRW            = 5'd11,
      CSRRS            = 5'd12,
      CSRRC            = 5'd13,
      CSRRWI           = 5'd14,
      CSRRSI           = 5'd15,
      CSRRCI           = 5'd16,
      INSTR_MISALIGNED = 5'd17,
      NOP              = 5'd31
   } fu_op_e;

   // Command toward the data memory
   typedef struct packed {
      fu_op_e                  mem_op;
      logic [`EADDR_WIDTH-1:0] eaddr;
      logic [`REG_WIDTH-1:0]   data;
   } mmu_cmd_s;

   // Command toward the CSR unit
   typedef struct packed {
      fu_op_e                csr_op;
      logic [11:0]           csr_addr;
      logic [`REG_WIDTH-1:0] data;
   } csr_cmd_s;

   function automatic logic is_load(fu_op_e op);
      return op inside {LB, LH, LW, LD, LBU, LHU, LWU};
   endfunction

   function automatic logic is_store(fu_op_e op);
      return op inside {SB, SH, SW, SD};
   endfunction

   function automatic logic is_csr(fu_op_e op);
      return op inside {CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};
   endfunction

   // Immediate forms take their operand from imm instead of rs1
   function automatic logic is_csr_imm(fu_op_e op);
      return op inside {CSRRWI, CSRRSI, CSRRCI};
   endfunction

   // Log2 of the access size in bytes
   function automatic logic [1:0] access_size(fu_op_e op);
      logic [1:0] size;
      case (op)
         LB, LBU, SB: size = 2'd0;
         LH, LHU, SH: size = 2'd1;
         LW, LWU, SW: size = 2'd2;
         default:     size = 2'd3;
      endcase
      return size;
   endfunction

endpackage

// File: common/mem_pipe_params.svh
`ifndef MEM_PIPE_PARAMS_SVH
`define MEM_PIPE_PARAMS_SVH

// Integer register width
`define REG_WIDTH 64

// Virtual address width carried by the PC
`define VADDR_WIDTH 39

// Effective address width after generation
`define EADDR_WIDTH 64

// Scratchpad size in double-words, based at address 0
`define DMEM_WORDS 256

// Slots in the command queue
`define CMD_QUEUE_DEPTH 4

`endif
